// ==== design/cam_pkg.sv ====
package cam_pkg;

  // one fifo entry, pixel in the upper bits
  typedef struct packed {
    logic [15:0] pixel;   // rgb565, r in [15:11], g in [10:5], b in [4:0]
    logic        sof;     // first pixel after a frame start
  } pixel_word_t;

  // control register layout, bit 0 is the enable
  typedef struct packed {
    logic swap_bytes;     // 0: first byte is the high half
    logic capture_en;     // capture the next frame
  } cam_ctrl_t;

  // host register map
  localparam logic [1:0] reg_ctrl   = 2'd0;  // cam_ctrl_t in the low bits
  localparam logic [1:0] reg_frames = 2'd1;  // wrapping frame count, write clears
  localparam logic [1:0] reg_status = 2'd2;  // bit 0 sticky overflow, write 1 clears

  // width of the control struct inside the 8-bit register
  localparam int ctrl_bits = $bits(cam_ctrl_t);

endpackage

// ==== design/cam_regs.sv ====
`timescale 1ns/1ns

module cam_regs (
  input  logic                pclk,
  input  logic                reset,
  input  logic                reg_wr,       // host write strobe
  input  logic [1:0]          reg_addr,
  input  logic [7:0]          reg_wdata,
  output logic [7:0]          reg_rdata,    // combinational from reg_addr
  input  logic                frame_start,  // one pulse per vsync fall
  input  logic                overflow,     // one pulse per dropped word
  output cam_pkg::cam_ctrl_t  ctrl
);

  logic [7:0] frame_cnt;   // wraps at 256
  logic       ovf_flag;    // sticky until host clears it

  logic wr_ctrl;
  logic wr_frames;
  logic wr_status;

  // address decode for writes
  assign wr_ctrl   = reg_wr && (reg_addr == cam_pkg::reg_ctrl);
  assign wr_frames = reg_wr && (reg_addr == cam_pkg::reg_frames);
  assign wr_status = reg_wr && (reg_addr == cam_pkg::reg_status);

  // control register, read by capture only at a frame start
  always_ff @(posedge pclk or posedge reset)
  begin
    if (reset)
    begin
      ctrl <= '0;                   // capture disabled, normal byte order
    end
    else if (wr_ctrl)
    begin
      ctrl <= cam_pkg::cam_ctrl_t'(reg_wdata[cam_pkg::ctrl_bits-1:0]);
    end
  end

  // frame counter, a host write clears it
  always_ff @(posedge pclk or posedge reset)
  begin
    if (reset)
    begin
      frame_cnt <= 8'd0;
    end
    else if (wr_frames)
    begin
      frame_cnt <= 8'd0;            // write value ignored
    end
    else if (frame_start)
    begin
      frame_cnt <= frame_cnt + 8'd1;
    end
  end

  // sticky overflow, a new drop beats a clear in the same cycle
  always_ff @(posedge pclk or posedge reset)
  begin
    if (reset)
    begin
      ovf_flag <= 1'b0;
    end
    else if (overflow)
    begin
      ovf_flag <= 1'b1;
    end
    else if (wr_status && reg_wdata[0])
    begin
      ovf_flag <= 1'b0;             // write 1 to clear
    end
  end

  // read mux
  always_comb
  begin
    reg_rdata = 8'd0;
    case (reg_addr)
      cam_pkg::reg_ctrl:   reg_rdata[cam_pkg::ctrl_bits-1:0] = ctrl;
      cam_pkg::reg_frames: reg_rdata = frame_cnt;
      cam_pkg::reg_status: reg_rdata[0] = ovf_flag;
      default:             reg_rdata = 8'd0;  // unmapped reads as zero
    endcase
  end

endmodule

// ==== design/pixel_capture.sv ====
`timescale 1ns/1ns

module pixel_capture (
  input  logic                  pclk,
  input  logic                  reset,
  input  logic                  vsync,
  input  logic                  href,
  input  logic [7:0]            din,
  input  cam_pkg::cam_ctrl_t    ctrl,        // sampled only at a frame start
  output logic                  push,
  output cam_pkg::pixel_word_t  push_word,
  output logic                  frame_start
);

  logic               vsync_q;      // previous vsync sample
  logic               vsync_fall;   // sampled 1-to-0 change
  cam_pkg::cam_ctrl_t frame_ctrl;   // settings frozen for the current frame
  logic               sof_pending;  // next pushed word gets sof
  logic               have_first;   // first byte of a pair is held
  logic [7:0]         first_byte;
  logic [15:0]        pair;         // assembled pixel from held byte and din

  assign vsync_fall = vsync_q && !vsync;

  // byte order from the frozen setting
  assign pair = frame_ctrl.swap_bytes ? {din, first_byte} : {first_byte, din};

  // frame tracking
  always_ff @(posedge pclk or posedge reset)
  begin
    if (reset)
    begin
      vsync_q     <= 1'b0;
      frame_start <= 1'b0;
      frame_ctrl  <= '0;
      sof_pending <= 1'b0;
    end
    else
    begin
      vsync_q     <= vsync;
      frame_start <= vsync_fall;    // pulses even with capture off
      if (vsync_fall)
      begin
        frame_ctrl  <= ctrl;        // whole frame captured or skipped
        sof_pending <= 1'b1;
      end
      else if (href && frame_ctrl.capture_en && have_first)
      begin
        sof_pending <= 1'b0;        // first word of the frame goes out now
      end
    end
  end

  // byte pairing, restarts whenever href is low
  always_ff @(posedge pclk or posedge reset)
  begin
    if (reset)
    begin
      have_first <= 1'b0;
      push       <= 1'b0;
    end
    else
    begin
      push <= 1'b0;                 // single-cycle strobe
      if (vsync_fall || !href || !frame_ctrl.capture_en)
      begin
        have_first <= 1'b0;
      end
      else if (!have_first)
      begin
        have_first <= 1'b1;         // hold the first byte
      end
      else
      begin
        have_first <= 1'b0;
        push       <= 1'b1;         // second byte completes the pixel
      end
    end
  end

  // payload registers, qualified by the control state above
  always_ff @(posedge pclk)
  begin
    if (href && !have_first)
    begin
      first_byte <= din;
    end
    if (href && frame_ctrl.capture_en && have_first && !vsync_fall)
    begin
      push_word.pixel <= pair;
      push_word.sof   <= sof_pending;
    end
  end

endmodule

// ==== design/pixel_fifo.sv ====
`timescale 1ns/1ns

module pixel_fifo #(
  parameter int abits = 4                    // depth is 2**abits
) (
  input  logic                  pclk,
  input  logic                  reset,
  input  logic                  push,
  input  cam_pkg::pixel_word_t  push_word,
  input  logic                  rd,          // pop strobe, ignored when empty
  output cam_pkg::pixel_word_t  dout,        // head entry, valid while empty is low
  output logic                  empty,
  output logic                  full,
  output logic                  overflow     // push dropped this cycle
);

  cam_pkg::pixel_word_t mem [2**abits];     // storage, no reset

  logic [abits-1:0] wr_ptr, wr_next, wr_succ;
  logic [abits-1:0] rd_ptr, rd_next, rd_succ;
  logic             full_next, empty_next;
  logic             do_pop;
  logic             do_push;

  assign do_pop   = rd && !empty;
  assign do_push  = push && (!full || do_pop);   // pop frees the slot
  assign overflow = push && full && !do_pop;

  assign wr_succ = wr_ptr + 1'b1;
  assign rd_succ = rd_ptr + 1'b1;

  // fall-through head
  assign dout = mem[rd_ptr];

  always_ff @(posedge pclk)
  begin
    if (do_push)
    begin
      mem[wr_ptr] <= push_word;
    end
  end

  // next pointers and flags
  always_comb
  begin
    wr_next    = wr_ptr;
    rd_next    = rd_ptr;
    full_next  = full;
    empty_next = empty;
    case ({do_push, do_pop})
      2'b10:
      begin
        wr_next    = wr_succ;
        empty_next = 1'b0;
        full_next  = (wr_succ == rd_ptr);   // writer caught up with reader
      end
      2'b01:
      begin
        rd_next    = rd_succ;
        full_next  = 1'b0;
        empty_next = (rd_succ == wr_ptr);   // reader caught up with writer
      end
      2'b11:
      begin
        wr_next = wr_succ;                  // occupancy unchanged, flags kept
        rd_next = rd_succ;
      end
      default:
      begin
        wr_next = wr_ptr;                   // idle
      end
    endcase
  end

  always_ff @(posedge pclk or posedge reset)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      full   <= 1'b0;
      empty  <= 1'b1;
    end
    else
    begin
      wr_ptr <= wr_next;
      rd_ptr <= rd_next;
      full   <= full_next;
      empty  <= empty_next;
    end
  end

endmodule

// ==== design/cam_capture_top.sv ====
`timescale 1ns/1ns

module cam_capture_top #(
  parameter int fifo_abits = 4               // fifo depth 2**fifo_abits
) (
  input  logic                  pclk,        // sensor pixel clock
  input  logic                  reset,
  input  logic                  vsync,
  input  logic                  href,
  input  logic [7:0]            din,
  input  logic                  rd,
  output cam_pkg::pixel_word_t  dout,
  output logic                  empty,
  output logic                  full,
  input  logic                  reg_wr,
  input  logic [1:0]            reg_addr,
  input  logic [7:0]            reg_wdata,
  output logic [7:0]            reg_rdata
);

  cam_pkg::cam_ctrl_t   ctrl;
  cam_pkg::pixel_word_t push_word;
  logic                 push;
  logic                 frame_start;
  logic                 overflow;

  cam_regs u_regs (
    .pclk        (pclk),
    .reset       (reset),
    .reg_wr      (reg_wr),
    .reg_addr    (reg_addr),
    .reg_wdata   (reg_wdata),
    .reg_rdata   (reg_rdata),
    .frame_start (frame_start),
    .overflow    (overflow),
    .ctrl        (ctrl)
  );

  pixel_capture u_capture (
    .pclk        (pclk),
    .reset       (reset),
    .vsync       (vsync),
    .href        (href),
    .din         (din),
    .ctrl        (ctrl),
    .push        (push),
    .push_word   (push_word),
    .frame_start (frame_start)
  );

  pixel_fifo #(
    .abits (fifo_abits)
  ) u_fifo (
    .pclk      (pclk),
    .reset     (reset),
    .push      (push),
    .push_word (push_word),
    .rd        (rd),
    .dout      (dout),
    .empty     (empty),
    .full      (full),
    .overflow  (overflow)
  );

endmodule

// ==== verif/cam_props.sv ====
`timescale 1ns/1ns

module cam_props (
  input logic pclk,
  input logic reset,
  input logic push,
  input logic rd,
  input logic empty,
  input logic full,
  input logic overflow
);

  // the two flags exclude each other
  flags_exclusive: assert property (@(posedge pclk) disable iff (reset) !(empty && full))
    else $error("fifo empty and full are both high");

  // a push into a full fifo with no pop is dropped and the fifo stays full
  drop_flags_overflow: assert property (@(posedge pclk) disable iff (reset)
    (push && full && !rd) |=> (full && $past(overflow)))
    else $error("push into a full fifo without a pop was not dropped with an overflow pulse");

  // first sampled cycle out of reset
  empty_after_reset: assert property (@(posedge pclk) $fell(reset) |-> empty)
    else $error("fifo not empty in the first cycle after reset");

endmodule

// ==== verif/cam_checker.sv ====
`timescale 1ns/1ns

module cam_checker #(
  parameter int abits = 4
) (
  input  logic                 pclk,
  input  logic                 reset,
  input  logic                 vsync,
  input  logic                 href,
  input  logic [7:0]           din,
  input  logic                 rd,
  input  cam_pkg::pixel_word_t dout,
  input  logic                 empty,
  input  logic                 full,
  input  logic                 reg_wr,
  input  logic [1:0]           reg_addr,
  input  logic [7:0]           reg_wdata,
  input  logic [7:0]           reg_rdata,
  output int                   errors,
  output int                   pops,
  output int                   drops
);

  localparam int depth = 1 << abits;

  cam_pkg::pixel_word_t exp_q [$];    // words the fifo should hold, head first
  cam_pkg::pixel_word_t pend_word;    // word on its way to the fifo
  cam_pkg::cam_ctrl_t   ctrl_m;       // host view of the control register
  cam_pkg::cam_ctrl_t   frame_m;      // setting frozen at the frame start
  logic                 push_pend;
  logic                 fs_pend;      // frame_start pulse due this cycle
  logic                 vsync_m;
  logic                 have_m;       // first byte held
  logic                 sof_m;
  logic                 ovf_m;        // sticky overflow flag
  logic                 ovf_evt;
  logic                 fall;
  logic [7:0]           first_m;
  logic [7:0]           frames_m;
  logic [7:0]           rdata_m;

  // reference pixel from a byte pair, first byte high unless swapped
  function automatic cam_pkg::pixel_word_t expect_word(input logic [7:0] first,
                                                       input logic [7:0] second,
                                                       input logic swap, input logic sof);
    cam_pkg::pixel_word_t w;
    w.pixel = swap ? {second, first} : {first, second};
    w.sof   = sof;
    return w;
  endfunction

  initial
  begin
    errors = 0;
    pops   = 0;
    drops  = 0;
  end

  always @(posedge pclk)
  begin
    if (reset)
    begin
      exp_q.delete();
      ctrl_m    = '0;
      frame_m   = '0;
      push_pend = 1'b0;
      fs_pend   = 1'b0;
      vsync_m   = 1'b0;
      have_m    = 1'b0;
      sof_m     = 1'b0;
      ovf_m     = 1'b0;
      frames_m  = 8'd0;
    end
    else
    begin
      if (empty !== (exp_q.size() == 0))
      begin
        $display("FAILED t=%0t empty exp %0b got %0b", $time, exp_q.size() == 0, empty);
        errors++;
      end
      if (full !== (exp_q.size() == depth))
      begin
        $display("FAILED t=%0t full exp %0b got %0b", $time, exp_q.size() == depth, full);
        errors++;
      end
      case (reg_addr)
        cam_pkg::reg_ctrl:   rdata_m = {6'd0, ctrl_m};
        cam_pkg::reg_frames: rdata_m = frames_m;
        cam_pkg::reg_status: rdata_m = {7'd0, ovf_m};
        default:             rdata_m = 8'd0;
      endcase
      if (reg_rdata !== rdata_m)
      begin
        $display("FAILED t=%0t reg_rdata exp %h got %h", $time, rdata_m, reg_rdata);
        errors++;
      end
      // head is visible whenever the fifo holds something
      if (exp_q.size() > 0)
      begin
        if (dout !== exp_q[0])
        begin
          $display("FAILED t=%0t dout exp %h got %h", $time, exp_q[0], dout);
          errors++;
        end
        if (rd)
        begin
          void'(exp_q.pop_front());
          pops++;
        end
      end
      ovf_evt = 1'b0;
      if (push_pend)
      begin
        if (exp_q.size() < depth)       // a pop this cycle already freed a slot
          exp_q.push_back(pend_word);
        else
        begin
          drops++;
          ovf_evt = 1'b1;
        end
      end
      if (reg_wr && reg_addr == cam_pkg::reg_frames)
        frames_m = 8'd0;
      else if (fs_pend)
        frames_m = frames_m + 8'd1;
      if (ovf_evt)
        ovf_m = 1'b1;                   // set beats clear
      else if (reg_wr && reg_addr == cam_pkg::reg_status && reg_wdata[0])
        ovf_m = 1'b0;
      // sensor side, pairs bytes under href
      fall      = vsync_m && !vsync;
      push_pend = 1'b0;
      if (fall)
      begin
        frame_m = ctrl_m;               // old control value, before this edge's write
        sof_m   = 1'b1;
        have_m  = 1'b0;
      end
      else if (!href || !frame_m.capture_en)
        have_m = 1'b0;
      else if (!have_m)
      begin
        have_m  = 1'b1;
        first_m = din;
      end
      else
      begin
        have_m    = 1'b0;
        push_pend = 1'b1;
        pend_word = expect_word(first_m, din, frame_m.swap_bytes, sof_m);
        sof_m     = 1'b0;
      end
      fs_pend = fall;
      vsync_m = vsync;
      if (reg_wr && reg_addr == cam_pkg::reg_ctrl)
        ctrl_m = cam_pkg::cam_ctrl_t'(reg_wdata[1:0]);
    end
  end

endmodule

// ==== verif/cam_tb.sv ====
`timescale 1ns/1ns

module cam_tb;

  localparam int abits          = 4;
  localparam int depth          = 1 << abits;
  localparam int frame_cycles   = 3 + 2 + 4 * (16 + 2);  // vsync, idle, four lines
  localparam int timeout_cycles = 1500;   // seven frames of 77 cycles, drains, host access

  logic                 pclk;
  logic                 reset;
  logic                 vsync;
  logic                 href;
  logic [7:0]           din;
  logic                 rd;
  cam_pkg::pixel_word_t dout;
  logic                 empty;
  logic                 full;
  logic                 reg_wr;
  logic [1:0]           reg_addr;
  logic [7:0]           reg_wdata;
  logic [7:0]           reg_rdata;
  int                   chk_errors;
  int                   pops;
  int                   drops;
  int                   tb_errors;
  int                   cycles;
  int                   mark_pops;
  int                   mark_drops;
  logic [31:0]          data_state;     // pixel bytes
  logic [31:0]          rd_state;       // reader pattern in test 5

  cam_capture_top #(.fifo_abits(abits)) DUT (
    .pclk(pclk), .reset(reset), .vsync(vsync), .href(href), .din(din),
    .rd(rd), .dout(dout), .empty(empty), .full(full),
    .reg_wr(reg_wr), .reg_addr(reg_addr), .reg_wdata(reg_wdata), .reg_rdata(reg_rdata)
  );

  cam_checker #(.abits(abits)) u_checker (
    .pclk(pclk), .reset(reset), .vsync(vsync), .href(href), .din(din),
    .rd(rd), .dout(dout), .empty(empty), .full(full),
    .reg_wr(reg_wr), .reg_addr(reg_addr), .reg_wdata(reg_wdata), .reg_rdata(reg_rdata),
    .errors(chk_errors), .pops(pops), .drops(drops)
  );

  bind pixel_fifo cam_props u_props (
    .pclk(pclk), .reset(reset), .push(push), .rd(rd),
    .empty(empty), .full(full), .overflow(overflow)
  );

  always #10 pclk = ~pclk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic step();
    @(posedge pclk);
    #2;                                 // drive just after the edge
  endtask

  task automatic check_val(input string name, input int got, input int exp);
    if (got != exp)
    begin
      $display("FAILED t=%0t %s exp %0d got %0d", $time, name, exp, got);
      tb_errors++;
    end
  endtask

  task automatic write_reg(input logic [1:0] addr, input logic [7:0] data);
    step();
    reg_wr    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    step();
    reg_wr = 1'b0;
  endtask

  task automatic check_reg(input logic [1:0] addr, input logic [7:0] exp);
    step();
    reg_addr = addr;
    @(negedge pclk);
    check_val("reg_rdata", int'(reg_rdata), int'(exp));
  endtask

  task automatic send_frame();
    step();
    vsync = 1'b1;
    repeat (3) step();
    vsync = 1'b0;                       // falling edge starts the frame
    step();
    repeat (4)
    begin
      repeat (16)
      begin
        step();
        href       = 1'b1;
        data_state = lcg_next(data_state);
        din        = data_state[23:16];
      end
      repeat (2)
      begin
        step();
        href = 1'b0;
      end
    end
  endtask

  task automatic drain();
    step();
    rd = 1'b1;
    @(negedge pclk);
    while (!empty)
    begin
      @(negedge pclk);
    end
    step();
  endtask

  task automatic mark();
    mark_pops  = pops;
    mark_drops = drops;
  endtask

  always @(posedge pclk)
  begin
    cycles++;
    if (cycles >= timeout_cycles)
    begin
      $display("timeout after %0d cycles, the run did not finish", cycles);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  initial
  begin
    pclk       = 1'b0;
    reset      = 1'b1;
    vsync      = 1'b0;
    href       = 1'b0;
    din        = 8'd0;
    rd         = 1'b0;
    reg_wr     = 1'b0;
    reg_addr   = 2'd0;
    reg_wdata  = 8'd0;
    tb_errors  = 0;
    cycles     = 0;
    data_state = 32'h58a2ef6b;
    rd_state   = ~32'h58a2ef6b;
    repeat (2) @(posedge pclk);
    #2 reset = 1'b0;
    // test 1 with capture off while the reader keeps asking
    mark();
    rd = 1'b1;
    send_frame();
    check_val("pops", pops - mark_pops, 0);
    check_val("empty", int'(empty), 1);
    check_reg(cam_pkg::reg_frames, 8'd1);
    // test 2 with capture on and normal byte order
    write_reg(cam_pkg::reg_ctrl, 8'h01);
    check_reg(cam_pkg::reg_ctrl, 8'h01);
    mark();
    send_frame();
    drain();
    check_val("pops", pops - mark_pops, 32);
    // test 3 sets swap mid-frame so it applies from the next frame
    mark();
    fork
      send_frame();
      begin
        repeat (40) step();
        write_reg(cam_pkg::reg_ctrl, 8'h03);
      end
    join
    send_frame();
    drain();
    check_val("pops", pops - mark_pops, 64);
    // test 4 stalls the reader for a whole frame
    write_reg(cam_pkg::reg_ctrl, 8'h01);
    mark();
    rd = 1'b0;
    send_frame();
    @(negedge pclk);
    check_val("full", int'(full), 1);
    check_val("drops", drops - mark_drops, 32 - depth);
    check_reg(cam_pkg::reg_status, 8'h01);
    drain();
    check_val("pops", pops - mark_pops, depth);
    write_reg(cam_pkg::reg_status, 8'h01);
    check_reg(cam_pkg::reg_status, 8'h00);
    // test 5 reader pops in about three cycles out of four
    mark();
    fork
      send_frame();
      repeat (frame_cycles)
      begin
        step();
        rd_state = lcg_next(rd_state);
        rd       = (rd_state[31:30] != 2'b00);
      end
    join
    drain();
    check_val("pops", pops - mark_pops, 32);
    check_val("drops", drops - mark_drops, 0);
    // test 6 reads and clears the frame counter
    send_frame();
    drain();
    check_reg(cam_pkg::reg_frames, 8'd7);
    write_reg(cam_pkg::reg_frames, 8'hff);
    check_reg(cam_pkg::reg_frames, 8'd0);
    repeat (3) step();
    $display("errors: testbench %0d checker %0d", tb_errors, chk_errors);
    if (tb_errors + chk_errors == 0)
    begin
      $display("PASS: all tests");
    end
    else
    begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
design/cam_pkg.sv
design/cam_regs.sv
design/pixel_capture.sv
design/pixel_fifo.sv
design/cam_capture_top.sv
verif/cam_props.sv
verif/cam_checker.sv
verif/cam_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cam_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SRCS    := $(wildcard design/*.sv verif/*.sv)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "FAIL: see errors above" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
